// ==== source/pipe_pkg.sv ====
`default_nettype none

// Shared widths and types for the EX/MEM/WB back half
package pipe_pkg;

    ////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////

    localparam int WORD_BITS    = 32;   // Data path width
    localparam int REG_SEL_BITS = 5;    // 32 architectural registers
    localparam int PC_BITS      = 10;   // Branch target word address

    ////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////

    typedef logic [WORD_BITS-1:0]    word_t;     // ALU result, load and store data
    typedef logic [REG_SEL_BITS-1:0] reg_sel_t;  // Destination register number
    typedef logic [PC_BITS-1:0]      pc_t;       // Redirect target
    typedef logic [1:0]              size_t;     // Access size code

    // Access size codes
    // 11 is not a legal encoding and behaves as a word
    localparam size_t SIZE_BYTE = 2'b00;
    localparam size_t SIZE_HALF = 2'b01;
    localparam size_t SIZE_WORD = 2'b10;

endpackage

`default_nettype wire

// ==== source/ex_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// EX/MEM register contents as seen by the memory stage
interface ex_mem_if;
    import pipe_pkg::*;

    pc_t      branch_target;    // Target if branch taken
    word_t    alu_result;       // Also the byte address
    reg_sel_t rd;               // Writeback register
    word_t    write_data;       // Store data, low bytes used

    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;       // Writeback from load, else ALU
    logic     reg_write;
    logic     alu_zero;         // Branch condition
    logic     branch;
    logic     jump;

    size_t    data_size;        // Byte, half or word
    logic     data_sign;        // Sign extend loads

    // Register drives everything
    modport reg_side (
        output branch_target, alu_result, rd, write_data,
        output mem_read, mem_write, mem_to_reg, reg_write, alu_zero, branch, jump,
        output data_size, data_sign
    );

    // Memory stage only reads
    modport mem_side (
        input branch_target, alu_result, rd, write_data,
        input mem_read, mem_write, mem_to_reg, reg_write, alu_zero, branch, jump,
        input data_size, data_sign
    );

endinterface

`default_nettype wire

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,          // Turn into bubble at next edge
    input  logic               stall,          // Hold current contents
    input  pipe_pkg::pc_t      branch_target,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::word_t    write_data,
    input  pipe_pkg::reg_sel_t rd,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               mem_to_reg,
    input  logic               reg_write,
    input  logic               alu_zero,
    input  logic               branch,
    input  logic               jump,
    input  logic               data_sign,
    input  pipe_pkg::size_t    data_size,
    ex_mem_if.reg_side         q
);
    import pipe_pkg::*;

    // Held control bits, before stall masking
    logic mem_read_r;
    logic mem_write_r;
    logic reg_write_r;
    logic branch_r;
    logic jump_r;

    ////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q.branch_target <= '0;
            q.alu_result    <= '0;
            q.write_data    <= '0;
            q.rd            <= '0;
            q.mem_to_reg    <= 1'b0;
            q.alu_zero      <= 1'b0;
            q.data_size     <= SIZE_BYTE;
            q.data_sign     <= 1'b0;
            mem_read_r      <= 1'b0;
            mem_write_r     <= 1'b0;
            reg_write_r     <= 1'b0;
            branch_r        <= 1'b0;
            jump_r          <= 1'b0;
        end else if (flush) begin   // Flush wins over stall
            q.branch_target <= '0;
            q.alu_result    <= '0;
            q.write_data    <= '0;
            q.rd            <= '0;
            q.mem_to_reg    <= 1'b0;
            q.alu_zero      <= 1'b0;
            q.data_size     <= SIZE_BYTE;
            q.data_sign     <= 1'b0;
            mem_read_r      <= 1'b0;
            mem_write_r     <= 1'b0;
            reg_write_r     <= 1'b0;
            branch_r        <= 1'b0;
            jump_r          <= 1'b0;
        end else if (!stall) begin
            q.branch_target <= branch_target;
            q.alu_result    <= alu_result;
            q.write_data    <= write_data;
            q.rd            <= rd;
            q.mem_to_reg    <= mem_to_reg;
            q.alu_zero      <= alu_zero;
            q.data_size     <= data_size;
            q.data_sign     <= data_sign;
            mem_read_r      <= mem_read;
            mem_write_r     <= mem_write;
            reg_write_r     <= reg_write;
            branch_r        <= branch;
            jump_r          <= jump;
        end
    end

    // Side effects suppressed while held, so the instruction
    // acts once, in the first cycle stall drops
    assign q.mem_read  = mem_read_r  & ~stall;
    assign q.mem_write = mem_write_r & ~stall;
    assign q.reg_write = reg_write_r & ~stall;  // Bubble into MEM/WB
    assign q.branch    = branch_r    & ~stall;
    assign q.jump      = jump_r      & ~stall;

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int NUM_WORDS = 1024
) (
    input  logic               clk,
    ex_mem_if.mem_side         ex,
    output logic               redirect,
    output pipe_pkg::pc_t      redirect_target,
    output pipe_pkg::word_t    load_data,
    output pipe_pkg::word_t    alu_result_out,
    output pipe_pkg::reg_sel_t rd_out,
    output logic               mem_to_reg_out,
    output logic               reg_write_out
);
    import pipe_pkg::*;

    localparam int WADDR_BITS = $clog2(NUM_WORDS);

    logic [3:0][7:0] mem [NUM_WORDS];   // Little-endian byte lanes

    logic [WADDR_BITS-1:0] word_addr;
    logic [1:0]            byte_off;    // Lane within word
    logic [3:0]            byte_en;
    logic [3:0][7:0]       store_lanes;
    logic [3:0][7:0]       read_lanes;
    logic [7:0]            load_byte;
    logic [15:0]           load_half;
    word_t                 load_ext;

    assign word_addr = ex.alu_result[WADDR_BITS+1:2];
    assign byte_off  = ex.alu_result[1:0];

    ////////////////////////////////////////////////
    // Store path
    ////////////////////////////////////////////////

    // Replicate low bytes over every lane, enables pick the target
    always_comb begin
        case (ex.data_size)
            SIZE_BYTE: begin
                byte_en     = 4'b0001 << byte_off;
                store_lanes = {4{ex.write_data[7:0]}};
            end
            SIZE_HALF: begin
                byte_en     = byte_off[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
                store_lanes = {2{ex.write_data[15:0]}};
            end
            default: begin  // SIZE_WORD and 11
                byte_en     = 4'b1111;
                store_lanes = ex.write_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i])
                    mem[word_addr][i] <= store_lanes[i];
            end
        end
    end

    ////////////////////////////////////////////////
    // Load path
    ////////////////////////////////////////////////

    assign read_lanes = mem[word_addr];     // Asynchronous read
    assign load_byte  = read_lanes[byte_off];
    assign load_half  = byte_off[1] ? read_lanes[3:2] : read_lanes[1:0];

    // Sign or zero extension
    always_comb begin
        case (ex.data_size)
            SIZE_BYTE: load_ext = {{(WORD_BITS-8){ex.data_sign & load_byte[7]}}, load_byte};
            SIZE_HALF: load_ext = {{(WORD_BITS-16){ex.data_sign & load_half[15]}}, load_half};
            default:   load_ext = read_lanes;
        endcase
    end

    assign load_data = ex.mem_read ? load_ext : '0;    // Zero when not a load

    // Branch resolution
    assign redirect        = ex.jump | (ex.branch & ex.alu_zero);
    assign redirect_target = ex.branch_target;

    // On to MEM/WB untouched
    assign alu_result_out = ex.alu_result;
    assign rd_out         = ex.rd;
    assign mem_to_reg_out = ex.mem_to_reg;
    assign reg_write_out  = ex.reg_write;

endmodule

`default_nettype wire

// ==== source/mem_wb_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  logic               clk,
    input  logic               rst,
    input  pipe_pkg::word_t    load_data,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::reg_sel_t rd,
    input  logic               mem_to_reg,
    input  logic               reg_write,
    output logic               wb_en,       // Register file write enable
    output pipe_pkg::reg_sel_t wb_rd,
    output pipe_pkg::word_t    wb_data
);
    import pipe_pkg::*;

    word_t wb_sel;  // Writeback source picked before the flop

    assign wb_sel = mem_to_reg ? load_data : alu_result;

    ////////////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////////////

    // Register file write port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end else begin
            wb_en   <= reg_write;   // Low for bubbles and stalls
            wb_rd   <= rd;
            wb_data <= wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_back_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_back_end #(
    parameter int NUM_WORDS = 1024      // Data memory depth in words
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,
    // Execute stage results
    input  pipe_pkg::pc_t      branch_target,
    input  pipe_pkg::word_t    alu_result,
    input  pipe_pkg::word_t    write_data,
    input  pipe_pkg::reg_sel_t rd,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               mem_to_reg,
    input  logic               reg_write,
    input  logic               alu_zero,
    input  logic               branch,
    input  logic               jump,
    input  logic               data_sign,
    input  pipe_pkg::size_t    data_size,
    // Fetch redirect
    output logic               redirect,
    output pipe_pkg::pc_t      redirect_target,
    // Register file write port
    output logic               wb_en,
    output pipe_pkg::reg_sel_t wb_rd,
    output pipe_pkg::word_t    wb_data
);
    import pipe_pkg::*;

    ex_mem_if ex_mem ();

    // Memory stage to MEM/WB
    word_t    mem_load_data;
    word_t    mem_alu_result;
    reg_sel_t mem_rd;
    logic     mem_mem_to_reg;
    logic     mem_reg_write;

    ex_mem_reg u_ex_mem_reg (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .stall         (stall),
        .branch_target (branch_target),
        .alu_result    (alu_result),
        .write_data    (write_data),
        .rd            (rd),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .alu_zero      (alu_zero),
        .branch        (branch),
        .jump          (jump),
        .data_sign     (data_sign),
        .data_size     (data_size),
        .q             (ex_mem.reg_side)
    );

    mem_stage #(
        .NUM_WORDS (NUM_WORDS)
    ) u_mem_stage (
        .clk             (clk),
        .ex              (ex_mem.mem_side),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .load_data       (mem_load_data),
        .alu_result_out  (mem_alu_result),
        .rd_out          (mem_rd),
        .mem_to_reg_out  (mem_mem_to_reg),
        .reg_write_out   (mem_reg_write)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk        (clk),
        .rst        (rst),
        .load_data  (mem_load_data),
        .alu_result (mem_alu_result),
        .rd         (mem_rd),
        .mem_to_reg (mem_mem_to_reg),
        .reg_write  (mem_reg_write),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== test/mem_back_end_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// Port level properties of the back end
module mem_back_end_chk (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic stall,
    input  logic reg_write,
    input  logic redirect,
    input  logic wb_en
);

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////

    wb_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wb_en))
        else $error("wb_en is unknown");

    // Flushed register is a bubble
    no_redirect_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !redirect)
        else $error("redirect high in the cycle after a flush");

    // Sampled, then not held, then written back
    wb_two_edges: assert property (@(posedge clk) disable iff (rst)
        ($past(reg_write && !stall && !flush) && !stall) |=> wb_en)
        else $error("wb_en missing two edges after reg_write");

endmodule

bind mem_back_end mem_back_end_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .stall     (stall),
    .reg_write (reg_write),
    .redirect  (redirect),
    .wb_en     (wb_en)
);

`default_nettype wire

// ==== test/mem_back_end_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_back_end_tb;
    import pipe_pkg::*;

    localparam int NUM_WORDS = 1024;
    localparam int N_WORD    = 32;     // Store, load, ALU triples
    localparam int N_SUB     = 64;     // Sub-word store and three loads
    localparam int N_BR      = 48;
    localparam int N_FLUSH   = 16;
    localparam int N_STALL   = 24;
    localparam int MAX_STALL = 5;
    // Cycles per test plus drain, doubled
    localparam int LIMIT = 2 * (10 + 64 + 3 * N_WORD + 4 * N_SUB + N_BR + 3 * N_FLUSH
                           + (MAX_STALL + 3) * N_STALL + 6 * 8) + 100;

    logic     clk = 1'b0;
    logic     rst;
    logic     flush;
    logic     stall;
    pc_t      branch_target;
    word_t    alu_result;
    word_t    write_data;
    reg_sel_t rd;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     reg_write;
    logic     alu_zero;
    logic     branch;
    logic     jump;
    logic     data_sign;
    size_t    data_size;
    logic     redirect;
    pc_t      redirect_target;
    logic     wb_en;
    reg_sel_t wb_rd;
    word_t    wb_data;

    logic [7:0] model [256];    // Byte image of the 64-word test region
    int       wb_due_q[$];      // Expected writebacks, cycle stamped
    reg_sel_t wb_rd_q[$];
    word_t    wb_data_q[$];
    int       rd_due_q[$];      // Expected redirects
    pc_t      rd_tgt_q[$];
    int       cyc = 0;          // Edges since time 0
    int       checks = 0;
    int       errors = 0;
    int       wb_seen = 0;
    int       wb_expected = 0;
    logic     reset_checked = 1'b0;
    string    cur_test = "reset";
    logic [31:0] rnd;

    always #4 clk = ~clk;       // 8 ns
    always @(posedge clk) cyc <= cyc + 1;

    mem_back_end #(.NUM_WORDS(NUM_WORDS)) DUT (.*);

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic void store_model(input word_t addr, input word_t data, input size_t sz);
        logic [7:0] a;
        a = addr[7:0];
        if (sz == SIZE_BYTE) begin
            model[a] = data[7:0];
        end else if (sz == SIZE_HALF) begin
            a[0] = 1'b0;            // Bit 1 picks the half
            model[a]        = data[7:0];
            model[a + 8'd1] = data[15:8];
        end else begin
            a[1:0] = 2'b00;
            for (int i = 0; i < 4; i++)
                model[a + 8'(i)] = data[8*i +: 8];
        end
    endfunction

    // Expected load value, little-endian
    function automatic word_t ref_load(input word_t addr, input size_t sz, input logic sgn);
        logic [7:0]  a;
        logic [15:0] h;
        a = addr[7:0];
        if (sz == SIZE_BYTE)
            return sgn ? {{24{model[a][7]}}, model[a]} : {24'b0, model[a]};
        if (sz == SIZE_HALF) begin
            a[0] = 1'b0;
            h = {model[a + 8'd1], model[a]};
            return sgn ? {{16{h[15]}}, h} : {16'b0, h};
        end
        a[1:0] = 2'b00;             // Word, and code 11
        return {model[a + 8'd3], model[a + 8'd2], model[a + 8'd1], model[a]};
    endfunction

    function automatic word_t rand_addr();
        logic [31:0] r;
        r = $urandom();
        return {24'b0, r[7:0]};     // Inside the filled region
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic expect_wb(input int due, input reg_sel_t r, input word_t d);
        wb_due_q.push_back(due);
        wb_rd_q.push_back(r);
        wb_data_q.push_back(d);
        wb_expected++;
    endtask

    task automatic expect_redirect(input int due, input pc_t t);
        rd_due_q.push_back(due);
        rd_tgt_q.push_back(t);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Bubble on every input
    task automatic idle_inputs();
        flush         <= 1'b0;
        stall         <= 1'b0;
        branch_target <= '0;
        alu_result    <= '0;
        write_data    <= '0;
        rd            <= '0;
        mem_read      <= 1'b0;
        mem_write     <= 1'b0;
        mem_to_reg    <= 1'b0;
        reg_write     <= 1'b0;
        alu_zero      <= 1'b0;
        branch        <= 1'b0;
        jump          <= 1'b0;
        data_sign     <= 1'b0;
        data_size     <= SIZE_WORD;
    endtask

    task automatic bubble();
        @(posedge clk);
        idle_inputs();
    endtask

    task automatic send_store(input word_t addr, input word_t data, input size_t sz);
        @(posedge clk);
        idle_inputs();
        alu_result <= addr;
        write_data <= data;
        data_size  <= sz;
        mem_write  <= 1'b1;
        store_model(addr, data, sz);
    endtask

    // Writeback lands two edges after the sampling edge
    task automatic send_load(input word_t addr, input size_t sz, input logic sgn, input reg_sel_t r);
        @(posedge clk);
        idle_inputs();
        alu_result <= addr;
        data_size  <= sz;
        data_sign  <= sgn;
        rd         <= r;
        mem_read   <= 1'b1;
        mem_to_reg <= 1'b1;
        reg_write  <= 1'b1;
        expect_wb(cyc + 3, r, ref_load(addr, sz, sgn));
    endtask

    task automatic send_alu(input word_t val, input reg_sel_t r);
        @(posedge clk);
        idle_inputs();
        alu_result <= val;
        rd         <= r;
        reg_write  <= 1'b1;
        expect_wb(cyc + 3, r, val);
    endtask

    task automatic send_branch(input logic br, input logic jmp, input logic z, input pc_t tgt);
        @(posedge clk);
        idle_inputs();
        branch        <= br;
        jump          <= jmp;
        alu_zero      <= z;
        branch_target <= tgt;
        if (jmp || (br && z))
            expect_redirect(cyc + 2, tgt);
    endtask

    // Store, writeback and taken branch, all dropped by flush
    task automatic send_flushed(input word_t addr, input word_t data);
        @(posedge clk);
        idle_inputs();
        flush         <= 1'b1;
        alu_result    <= addr;
        write_data    <= data;
        mem_write     <= 1'b1;
        reg_write     <= 1'b1;
        rd            <= data[4:0];
        branch        <= 1'b1;
        alu_zero      <= 1'b1;
        jump          <= data[5];
        branch_target <= data[17:8];
    endtask

    // Store, jump and ALU writeback, held k edges in EX/MEM
    task automatic send_stalled(input word_t addr, input word_t data, input int k);
        @(posedge clk);
        idle_inputs();
        alu_result    <= addr;
        write_data    <= data;
        rd            <= data[4:0];
        mem_write     <= 1'b1;
        reg_write     <= 1'b1;
        jump          <= 1'b1;
        branch_target <= data[17:8];
        store_model(addr, data, SIZE_WORD);
        expect_redirect(cyc + 2 + k, data[17:8]);
        expect_wb(cyc + 3 + k, data[4:0], addr);
        repeat (k) begin
            @(posedge clk);
            idle_inputs();
            stall <= 1'b1;
        end
        bubble();
    endtask

    task automatic finish_test(input int err_before);
        bubble();
        while (wb_due_q.size() != 0 || rd_due_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        $display("test %s done, %0d errors", cur_test, errors - err_before);
    endtask

    //////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && !reset_checked) begin
            check("wb_en", 32'd0, 32'(wb_en));
            check("redirect", 32'd0, 32'(redirect));
            check("wb_data", 32'd0, wb_data);
            check("wb_rd", 32'd0, 32'(wb_rd));
            check("redirect_target", 32'd0, 32'(redirect_target));
            reset_checked = 1'b1;
        end else if (!rst) begin
            if (wb_en) begin
                wb_seen++;
                if (wb_due_q.size() == 0) begin
                    errors++;
                    $display("Unexpected writeback to r%0d in test %s", wb_rd, cur_test);
                end else begin
                    check("wb_cycle", wb_due_q.pop_front(), cyc);
                    check("wb_rd", 32'(wb_rd_q.pop_front()), 32'(wb_rd));
                    check("wb_data", wb_data_q.pop_front(), wb_data);
                end
            end else if (wb_due_q.size() != 0 && wb_due_q[0] <= cyc) begin
                errors++;
                $display("Missing writeback due at cycle %0d in test %s", wb_due_q[0], cur_test);
                void'(wb_due_q.pop_front());
                void'(wb_rd_q.pop_front());
                void'(wb_data_q.pop_front());
            end
            if (redirect) begin
                if (rd_due_q.size() == 0) begin
                    errors++;
                    $display("Unexpected redirect at cycle %0d in test %s", cyc, cur_test);
                end else begin
                    check("redirect_cycle", rd_due_q.pop_front(), cyc);
                    check("redirect_target", 32'(rd_tgt_q.pop_front()), 32'(redirect_target));
                end
            end else if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
                errors++;
                $display("Missing redirect due at cycle %0d in test %s", rd_due_q[0], cur_test);
                void'(rd_due_q.pop_front());
                void'(rd_tgt_q.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        while (cyc < LIMIT)
            @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", cyc);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int     e0;
        int     k;
        word_t  a;
        size_t  sz;
        logic   count_ok;
        rst = 1'b1;
        idle_inputs();
        void'($urandom(32'h37c1d7e1));
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;                // Reset values checked by compare
        finish_test(e0);

        cur_test = "word_alu";
        e0 = errors;
        for (int i = 0; i < 64; i++) begin     // Fill the region first
            rnd = $urandom();
            send_store(32'(4 * i), rnd, SIZE_WORD);
        end
        for (int i = 0; i < N_WORD; i++) begin
            rnd = $urandom();
            send_store(rand_addr(), rnd, SIZE_WORD);
            send_load(rand_addr(), {1'b1, rnd[1]}, rnd[0], rnd[12:8]);   // Code 11 too
            rnd = $urandom();
            send_alu(rnd, rnd[4:0]);
        end
        finish_test(e0);

        cur_test = "sub_word";
        e0 = errors;
        for (int i = 0; i < N_SUB; i++) begin
            a = rand_addr();
            a[1:0] = 2'(i % 4);     // Walk every lane
            rnd = $urandom();
            sz = (i % 8 < 4) ? SIZE_BYTE : SIZE_HALF;
            send_store(a, rnd, sz);
            send_load(a, sz, 1'b1, 5'(i));
            send_load(a, sz, 1'b0, 5'(i + 1));
            send_load(a, SIZE_WORD, 1'b0, 5'(i + 2));
        end
        finish_test(e0);

        cur_test = "branch";
        e0 = errors;
        for (int i = 0; i < N_BR; i++) begin
            rnd = $urandom();
            send_branch(rnd[0], rnd[1] & rnd[2], rnd[3], rnd[17:8]);
        end
        finish_test(e0);

        cur_test = "flush";
        e0 = errors;
        for (int i = 0; i < N_FLUSH; i++) begin
            a = rand_addr();
            rnd = $urandom();
            send_flushed(a, rnd);
            send_load(a, SIZE_WORD, 1'b0, rnd[4:0]);   // Old contents expected
        end
        finish_test(e0);

        cur_test = "stall";
        e0 = errors;
        for (int i = 0; i < N_STALL; i++) begin
            a = rand_addr();
            rnd = $urandom();
            k = 1 + int'(rnd[31:29]) % MAX_STALL;
            send_stalled(a, rnd, k);
            send_load(a, SIZE_WORD, 1'b0, 5'd1);
        end
        finish_test(e0);

        count_ok = (wb_seen == wb_expected);
        if (!count_ok)
            $display("Writeback count %0d does not match model count %0d", wb_seen, wb_expected);
        $display("checks %0d, errors %0d, writebacks %0d", checks, errors, wb_seen);
        if (errors == 0 && count_ok)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/pipe_pkg.sv
source/ex_mem_if.sv
source/ex_mem_reg.sv
source/mem_stage.sv
source/mem_wb_reg.sv
source/mem_back_end.sv
test/mem_back_end_chk.sv
test/mem_back_end_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of mem_back_end_tb
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module mem_back_end_tb \
    -o mem_back_end_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mem_back_end_sim > sim.log 2>&1
cat sim.log
! grep -q "TB FAILED" sim.log && grep -q "TB PASSED" sim.log \
    || { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
